//--- logic/gb_memmap_pkg.sv
// ------------------------------------------------
// CPU address map and I/O register addresses
// ------------------------------------------------
`default_nettype none

package gb_memmap_pkg;

	localparam int ADDR_W      = 16;
	localparam int DATA_W      = 8;

	// I/O registers
	localparam logic [15:0] REG_P1   = 16'hFF00; // joypad
	localparam logic [15:0] REG_SB   = 16'hFF01; // serial data, reads FF
	localparam logic [15:0] REG_SC   = 16'hFF02; // serial control
	localparam logic [15:0] REG_IF   = 16'hFF0F;
	localparam logic [15:0] REG_BOOT = 16'hFF50; // boot overlay disable
	localparam logic [15:0] REG_SVBK = 16'hFF70; // wram bank, colour only
	localparam logic [15:0] REG_IE   = 16'hFFFF;

	localparam int WRAM_OFS_W  = 13; // C000..DFFF window
	localparam int WRAM_PHYS_W = 15; // 8 banks of 4k
	localparam int HRAM_W      = 7;

	localparam logic [7:0] BOOT_KEY_CGB  = 8'h11;
	localparam logic [7:0] FAST_BOOT_TAG = 8'h42; // seen by boot code at FF50

	// one window offset, seen flat or as bank bit + page offset
	typedef union packed {
		logic [WRAM_OFS_W-1:0] flat;
		struct packed {
			logic        bank_sel; // 1 -> D000 page, switchable
			logic [11:0] page_ofs;
		} paged;
	} wram_ofs_u;

endpackage

`default_nettype wire

//--- logic/gb_irq_pkg.sv
// ------------------------------------------------
// interrupt sources, lower index wins
// ------------------------------------------------
`default_nettype none

package gb_irq_pkg;

	localparam int IRQ_N = 5;

	// bit positions in IF / IE
	localparam int IRQ_VBLANK = 0;
	localparam int IRQ_LCD    = 1;
	localparam int IRQ_TIMER  = 2;
	localparam int IRQ_SERIAL = 3;
	localparam int IRQ_JOYPAD = 4;

	// rst vectors 40, 48 .. 60
	localparam logic [7:0] IRQ_VEC_BASE = 8'h40;
	localparam logic [7:0] IRQ_VEC_STEP = 8'd8;
	localparam logic [7:0] IRQ_VEC_NONE = 8'h55; // nothing pending

endpackage

`default_nettype wire

//--- logic/spram.sv
// ------------------------------------------------
// byte wide, q one cycle after address, write-first
// ------------------------------------------------
`default_nettype none

module spram #(
	parameter int AW = 8
) (
	input  logic          clk_cpu,
	input  logic [AW-1:0] address,
	input  logic          wren,
	input  logic [7:0]    data,
	output logic [7:0]    q
);

	logic [7:0] mem [0:(1<<AW)-1];

	always_ff @(posedge clk_cpu) begin
		if (wren) begin
			mem[address] <= data;
			q <= data; // new data shows on q
		end else begin
			q <= mem[address];
		end
	end

endmodule

`default_nettype wire

//--- logic/cpu_bus_mux.sv
// ------------------------------------------------
// read data valid one cycle after the address
// RAM data comes late from the RAMs, not registered here
// ------------------------------------------------
`default_nettype none

module cpu_bus_mux
	import gb_memmap_pkg::*;
(
	input  logic              clk_cpu,
	input  logic              reset,
	input  logic              cgb_mode,
	input  logic              fast_boot,
	input  logic [ADDR_W-1:0] cpu_addr,
	input  logic              irq_ack,
	input  logic              boot_active,
	input  logic [DATA_W-1:0] p1_rdata,
	input  logic [DATA_W-1:0] sc_rdata,
	input  logic [DATA_W-1:0] if_rdata,
	input  logic [DATA_W-1:0] ie_rdata,
	input  logic [DATA_W-1:0] svbk_rdata,
	input  logic [DATA_W-1:0] wram_rdata,
	input  logic [DATA_W-1:0] hram_rdata,
	input  logic [DATA_W-1:0] rom_rdata,
	input  logic [DATA_W-1:0] irq_vector,
	output logic              sel_p1,
	output logic              sel_sc,
	output logic              sel_irq_if,
	output logic              sel_irq_ie,
	output logic              sel_svbk,
	output logic              sel_wram,
	output logic              sel_hram,
	output logic              sel_rom,
	output logic [DATA_W-1:0] cpu_rdata
);

	logic              sel_fast; // boot code probes FF50
	logic [DATA_W-1:0] rd_byte;
	logic [DATA_W-1:0] rd_q;
	logic              wram_d;
	logic              hram_d;

	// ------------------------------------------------
	// address decode
	// ------------------------------------------------
	assign sel_p1     = cpu_addr == REG_P1;
	assign sel_sc     = cpu_addr == REG_SC;
	assign sel_irq_if = cpu_addr == REG_IF;
	assign sel_irq_ie = cpu_addr == REG_IE;
	assign sel_svbk   = cgb_mode && cpu_addr == REG_SVBK; // absent in mono
	assign sel_wram   = cpu_addr >= 16'hC000 && cpu_addr <= 16'hFDFF; // incl. echo
	assign sel_hram   = cpu_addr[15:7] == 9'h1FF && cpu_addr != REG_IE;
	// rom plus cart ram at A000..BFFF
	assign sel_rom    = !cpu_addr[15] || cpu_addr[15:13] == 3'b101;
	assign sel_fast   = fast_boot && boot_active && cpu_addr == REG_BOOT;

	// non-RAM sources, SB and holes fall through to FF
	always_comb begin
		rd_byte = 8'hFF;
		if (irq_ack)
			rd_byte = irq_vector; // ack cycle wins
		else if (sel_fast)
			rd_byte = FAST_BOOT_TAG;
		else if (sel_p1)
			rd_byte = p1_rdata;
		else if (sel_sc)
			rd_byte = sc_rdata;
		else if (sel_irq_if)
			rd_byte = if_rdata;
		else if (sel_irq_ie)
			rd_byte = ie_rdata;
		else if (sel_svbk)
			rd_byte = svbk_rdata;
		else if (sel_rom)
			rd_byte = rom_rdata;
	end

	// ------------------------------------------------
	// output stage
	// ------------------------------------------------
	always_ff @(posedge clk_cpu) begin
		rd_q <= rd_byte;
		if (reset) begin
			wram_d <= 1'b0;
			hram_d <= 1'b0;
		end else begin
			wram_d <= sel_wram && !irq_ack; // align with ram q
			hram_d <= sel_hram && !irq_ack;
		end
	end

	assign cpu_rdata = wram_d ? wram_rdata :
	                   hram_d ? hram_rdata :
	                   rd_q;

endmodule

`default_nettype wire

//--- logic/irq_controller.sv
// ------------------------------------------------
// IF/IE, lowest pending+enabled index has priority
// ------------------------------------------------
`default_nettype none

module irq_controller
	import gb_irq_pkg::*;
(
	input  logic       clk_cpu,
	input  logic       reset,
	input  logic [7:0] cpu_wdata,
	input  logic       cpu_wr,
	input  logic       sel_irq_if,
	input  logic       sel_irq_ie,
	input  logic       irq_ack,
	input  logic       vblank,     // level
	input  logic       lcd_irq,    // 1-cycle pulse
	input  logic       timer_irq,  // 1-cycle pulse
	input  logic       serial_irq, // 1-cycle pulse
	input  logic [7:0] key_lines,  // low active rows
	output logic [7:0] if_rdata,
	output logic [7:0] ie_rdata,
	output logic       irq,
	output logic [7:0] irq_vector
);

	logic [IRQ_N-1:0] if_r;
	logic [IRQ_N-1:0] ie_r;
	logic [IRQ_N-1:0] pending;
	logic [IRQ_N-1:0] set_bits;
	logic [IRQ_N-1:0] ack_mask; // one-hot, flag cleared by ack
	logic [2:0]       vec_idx;
	logic             vblank_d;
	logic [7:0]       key_d;

	assign pending = if_r & ie_r;
	assign irq     = |pending;

	// new events this cycle
	always_comb begin
		set_bits             = '0;
		set_bits[IRQ_VBLANK] = vblank && !vblank_d; // rising edge only
		set_bits[IRQ_LCD]    = lcd_irq;
		set_bits[IRQ_TIMER]  = timer_irq;
		set_bits[IRQ_SERIAL] = serial_irq;
		set_bits[IRQ_JOYPAD] = |(key_d & ~key_lines); // any key going low
	end

	// scan down so the lowest index ends up chosen
	always_comb begin
		ack_mask = '0;
		vec_idx  = '0;
		for (int i = IRQ_N - 1; i >= 0; i--) begin
			if (pending[i]) begin
				ack_mask    = '0;
				ack_mask[i] = 1'b1;
				vec_idx     = 3'(i);
			end
		end
	end

	assign irq_vector = irq ? IRQ_VEC_BASE + IRQ_VEC_STEP * {5'd0, vec_idx} : IRQ_VEC_NONE;

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			if_r     <= '0;
			ie_r     <= '0;
			vblank_d <= 1'b0;
			key_d    <= 8'hFF; // released
		end else begin
			vblank_d <= vblank;
			key_d    <= key_lines;
			if (cpu_wr && sel_irq_if)
				if_r <= cpu_wdata[IRQ_N-1:0]; // cpu write replaces all
			else if (irq_ack)
				if_r <= (if_r | set_bits) & ~ack_mask;
			else
				if_r <= if_r | set_bits;
			if (cpu_wr && sel_irq_ie)
				ie_r <= cpu_wdata[IRQ_N-1:0];
		end
	end

	assign if_rdata = {3'b111, if_r};
	assign ie_rdata = {3'b000, ie_r};

endmodule

`default_nettype wire

//--- logic/joypad.sv
// ------------------------------------------------
// joystick bits are high when pressed
// ------------------------------------------------
`default_nettype none

module joypad (
	input  logic       clk_cpu,
	input  logic       reset,
	input  logic [7:0] cpu_wdata,
	input  logic       cpu_wr,
	input  logic       sel_p1,
	input  logic [7:0] joystick, // start,select,b,a,down,up,left,right
	output logic [7:0] p1_rdata,
	output logic [7:0] key_lines
);

	logic [1:0] p54;     // 0 selects that row
	logic [3:0] row_dir;
	logic [3:0] row_btn;

	// low active rows forced high when not selected
	assign row_dir = ~{joystick[3], joystick[2], joystick[1], joystick[0]} | {4{p54[0]}};
	assign row_btn = ~{joystick[7], joystick[6], joystick[5], joystick[4]} | {4{p54[1]}};

	always_ff @(posedge clk_cpu) begin
		if (reset)
			p54 <= 2'b00;
		else if (sel_p1 && cpu_wr)
			p54 <= cpu_wdata[5:4];
	end

	assign key_lines = {row_dir, row_btn}; // watched for falling edges
	assign p1_rdata  = {2'b11, p54, row_dir & row_btn};

endmodule

`default_nettype wire

//--- logic/serial_ctrl.sv
// ------------------------------------------------
// dummy link port, no data shifted, only the irq
// ------------------------------------------------
`default_nettype none

module serial_ctrl #(
	parameter int SERIAL_DIV_W = 9
) (
	input  logic       clk_cpu,
	input  logic       reset,
	input  logic [7:0] cpu_wdata,
	input  logic       cpu_wr,
	input  logic       sel_sc,
	output logic [7:0] sc_rdata,
	output logic       serial_irq
);

	logic                    sc_start;
	logic                    sc_clk;  // internal clock select
	logic [SERIAL_DIV_W-1:0] div;
	logic [3:0]              bit_cnt; // underflows still to go

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			sc_start   <= 1'b0;
			sc_clk     <= 1'b0;
			div        <= '1;
			bit_cnt    <= 4'd8;
			serial_irq <= 1'b0;
		end else begin
			serial_irq <= 1'b0;
			if (sel_sc && cpu_wr) begin
				sc_start <= cpu_wdata[7];
				sc_clk   <= cpu_wdata[0];
				if (cpu_wdata[7]) begin // restart transfer
					div     <= '1;
					bit_cnt <= 4'd8;
				end
			end else if (sc_start && sc_clk) begin
				div <= div - 1'b1;
				if (div == '0 && bit_cnt != 4'd0)
					bit_cnt <= bit_cnt - 4'd1;
				if (bit_cnt == 4'd0) begin // byte done
					serial_irq <= 1'b1;
					sc_start   <= 1'b0;
					div        <= '1;
					bit_cnt    <= 4'd8;
				end
			end
		end
	end

	assign sc_rdata = {sc_start, 6'h3F, sc_clk};

endmodule

`default_nettype wire

//--- logic/work_ram.sv
// ------------------------------------------------
// wram C000..FDFF (echo incl.), D000 page banked in colour mode
// ------------------------------------------------
`default_nettype none

module work_ram
	import gb_memmap_pkg::*;
(
	input  logic              clk_cpu,
	input  logic              reset,
	input  logic              cgb_mode,
	input  logic [ADDR_W-1:0] cpu_addr,
	input  logic [DATA_W-1:0] cpu_wdata,
	input  logic              cpu_wr,
	input  logic              sel_wram,
	input  logic              sel_hram,
	input  logic              sel_svbk,
	output logic [DATA_W-1:0] wram_rdata,
	output logic [DATA_W-1:0] hram_rdata,
	output logic [DATA_W-1:0] svbk_rdata
);

	logic [2:0]             bank;     // SVBK, 1..7
	logic [2:0]             bank_eff;
	wram_ofs_u              ofs;
	logic [WRAM_PHYS_W-1:0] phys;

	always_ff @(posedge clk_cpu) begin
		if (reset)
			bank <= 3'd1;
		else if (sel_svbk && cpu_wr && cgb_mode)
			bank <= (cpu_wdata[2:0] == 3'd0) ? 3'd1 : cpu_wdata[2:0]; // 0 -> 1
	end

	assign bank_eff   = cgb_mode ? bank : 3'd1; // mono: fixed 8k
	assign svbk_rdata = {5'h1F, bank};

	always_comb begin
		ofs.flat = cpu_addr[WRAM_OFS_W-1:0];
		if (ofs.paged.bank_sel)
			phys = {bank_eff, ofs.paged.page_ofs};
		else
			phys = {3'd0, ofs.paged.page_ofs}; // C000 page always bank 0
	end

	spram #(.AW(WRAM_PHYS_W)) u_wram (
		.clk_cpu, .address(phys), .wren(sel_wram && cpu_wr), .data(cpu_wdata), .q(wram_rdata)
	);

	// FF80..FFFE
	spram #(.AW(HRAM_W)) u_hram (
		.clk_cpu, .address(cpu_addr[HRAM_W-1:0]), .wren(sel_hram && cpu_wr),
		.data(cpu_wdata), .q(hram_rdata)
	);

endmodule

`default_nettype wire

//--- logic/cart_rom_ctrl.sv
// ------------------------------------------------
// boot ROM overlays cart ROM until FF50 written
// bios_rdata must be valid for 0000..08FF
// ------------------------------------------------
`default_nettype none

module cart_rom_ctrl
	import gb_memmap_pkg::*;
(
	input  logic              clk_cpu,
	input  logic              reset,
	input  logic              cgb_mode,
	input  logic [ADDR_W-1:0] cpu_addr,
	input  logic [DATA_W-1:0] cpu_wdata,
	input  logic              cpu_rd,
	input  logic              cpu_wr,
	input  logic              sel_rom,    // rom or cart ram
	input  logic [DATA_W-1:0] cart_rdata,
	input  logic [DATA_W-1:0] bios_rdata,
	output logic [ADDR_W-1:0] cart_addr,
	output logic [DATA_W-1:0] cart_wdata,
	output logic              cart_rd,
	output logic              cart_wr,
	output logic [11:0]       bios_addr,
	output logic [DATA_W-1:0] rom_rdata,
	output logic              boot_active
);

	logic boot_key;   // disable value for current mode
	logic bios_lo;    // 0000..00FF
	logic bios_hi;    // 0200..08FF, colour only
	logic use_bios;

	assign boot_key = cgb_mode ? (cpu_wdata == BOOT_KEY_CGB) : cpu_wdata[0];

	always_ff @(posedge clk_cpu) begin
		if (reset)
			boot_active <= 1'b1;
		else if (cpu_wr && cpu_addr == REG_BOOT && boot_key)
			boot_active <= 1'b0; // one-way until reset
	end

	// ------------------------------------------------
	// overlay, header 0100..01FF always from cart
	// ------------------------------------------------
	assign bios_lo  = cpu_addr[15:8] == 8'h00;
	assign bios_hi  = cpu_addr >= 16'h0200 && cpu_addr <= 16'h08FF;
	assign use_bios = boot_active && (bios_lo || (cgb_mode && bios_hi));

	assign bios_addr = cpu_addr[11:0];
	assign rom_rdata = use_bios ? bios_rdata : cart_rdata;

	// cart bus follows the cpu directly
	assign cart_addr  = cpu_addr;
	assign cart_wdata = cpu_wdata;
	assign cart_rd    = sel_rom && cpu_rd;
	assign cart_wr    = sel_rom && cpu_wr; // mbc writes land here too

endmodule

`default_nettype wire

//--- logic/gb_bus_top.sv
// ------------------------------------------------
// bus glue around an external CPU, no video/audio/timer
// timer and lcd irqs come in as pulses, vblank as level
// ------------------------------------------------
`default_nettype none

module gb_bus_top
	import gb_memmap_pkg::*;
#(
	parameter int SERIAL_DIV_W = 9
) (
	input  logic              clk_cpu,
	input  logic              reset,
	input  logic              cgb_mode,
	input  logic              fast_boot,
	input  logic [7:0]        joystick,
	input  logic [ADDR_W-1:0] cpu_addr,
	input  logic [DATA_W-1:0] cpu_wdata,
	input  logic              cpu_rd,
	input  logic              cpu_wr,
	input  logic              irq_ack,
	input  logic              vblank,
	input  logic              lcd_irq,
	input  logic              timer_irq,
	input  logic [DATA_W-1:0] cart_rdata,
	input  logic [DATA_W-1:0] bios_rdata,
	output logic [DATA_W-1:0] cpu_rdata,
	output logic              irq,
	output logic [DATA_W-1:0] irq_vector,
	output logic [ADDR_W-1:0] cart_addr,
	output logic [DATA_W-1:0] cart_wdata,
	output logic              cart_rd,
	output logic              cart_wr,
	output logic [11:0]       bios_addr
);

	// unit selects from the decoder
	logic sel_p1;
	logic sel_sc;
	logic sel_irq_if;
	logic sel_irq_ie;
	logic sel_svbk;
	logic sel_wram;
	logic sel_hram;
	logic sel_rom;

	// read data back from the units
	logic [DATA_W-1:0] p1_rdata;
	logic [DATA_W-1:0] sc_rdata;
	logic [DATA_W-1:0] if_rdata;
	logic [DATA_W-1:0] ie_rdata;
	logic [DATA_W-1:0] svbk_rdata;
	logic [DATA_W-1:0] wram_rdata; // one cycle late
	logic [DATA_W-1:0] hram_rdata; // one cycle late
	logic [DATA_W-1:0] rom_rdata;

	logic       boot_active;
	logic       serial_irq;
	logic [7:0] key_lines;

	cpu_bus_mux u_mux (
		.clk_cpu, .reset, .cgb_mode, .fast_boot, .cpu_addr, .irq_ack, .boot_active,
		.p1_rdata, .sc_rdata, .if_rdata, .ie_rdata, .svbk_rdata,
		.wram_rdata, .hram_rdata, .rom_rdata, .irq_vector,
		.sel_p1, .sel_sc, .sel_irq_if, .sel_irq_ie, .sel_svbk,
		.sel_wram, .sel_hram, .sel_rom, .cpu_rdata
	);

	irq_controller u_irq (
		.clk_cpu, .reset, .cpu_wdata, .cpu_wr, .sel_irq_if, .sel_irq_ie, .irq_ack,
		.vblank, .lcd_irq, .timer_irq, .serial_irq, .key_lines,
		.if_rdata, .ie_rdata, .irq, .irq_vector
	);

	joypad u_joy (
		.clk_cpu, .reset, .cpu_wdata, .cpu_wr, .sel_p1, .joystick,
		.p1_rdata, .key_lines
	);

	serial_ctrl #(.SERIAL_DIV_W(SERIAL_DIV_W)) u_serial (
		.clk_cpu, .reset, .cpu_wdata, .cpu_wr, .sel_sc,
		.sc_rdata, .serial_irq
	);

	work_ram u_wram (
		.clk_cpu, .reset, .cgb_mode, .cpu_addr, .cpu_wdata, .cpu_wr,
		.sel_wram, .sel_hram, .sel_svbk,
		.wram_rdata, .hram_rdata, .svbk_rdata
	);

	cart_rom_ctrl u_cart (
		.clk_cpu, .reset, .cgb_mode, .cpu_addr, .cpu_wdata, .cpu_rd, .cpu_wr,
		.sel_rom, .cart_rdata, .bios_rdata,
		.cart_addr, .cart_wdata, .cart_rd, .cart_wr, .bios_addr,
		.rom_rdata, .boot_active
	);

endmodule

`default_nettype wire

//--- testbench/tb_gb_bus_checks.sv
// ------------------------------------------------
// CPU bus driver and checkers
// each task starts and ends on a falling edge
// ------------------------------------------------
`default_nettype none

module tb_gb_bus_checks
	import gb_memmap_pkg::*;
(
	input  logic              clk_cpu,
	input  logic              reset,
	input  logic [DATA_W-1:0] cpu_rdata,
	input  logic              irq,
	input  logic [DATA_W-1:0] irq_vector,
	input  logic              cart_rd,
	input  logic              cart_wr,
	input  logic [ADDR_W-1:0] cart_addr,
	input  logic [DATA_W-1:0] cart_wdata,
	output logic [ADDR_W-1:0] cpu_addr,
	output logic [DATA_W-1:0] cpu_wdata,
	output logic              cpu_rd,
	output logic              cpu_wr,
	output logic              irq_ack
);
	timeunit 1ns;
	timeprecision 100ps;

	int errors = 0;
	int checks = 0; // checks issued by the tasks

	logic              chk_en;   // read or ack issued this cycle
	logic [DATA_W-1:0] exp_data;
	logic [DATA_W-1:0] exp_q;    // expectation for the following edge
	logic [ADDR_W-1:0] addr_q;
	logic              vec_en;
	logic              exp_irq;
	logic [DATA_W-1:0] exp_vec;

	initial begin
		cpu_addr  = '0;
		cpu_wdata = '0;
		cpu_rd    = 1'b0;
		cpu_wr    = 1'b0;
		irq_ack   = 1'b0;
		chk_en    = 1'b0;
		exp_data  = '0;
		vec_en    = 1'b0;
		exp_irq   = 1'b0;
		exp_vec   = '0;
	end

	// ROM below 8000 plus cart RAM A000..BFFF
	function automatic logic in_cart(input logic [15:0] a);
		return !a[15] || (a >= 16'hA000 && a <= 16'hBFFF);
	endfunction

	// ------------------------------------------------
	// bus tasks
	// ------------------------------------------------
	task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
		cpu_addr  = addr;
		cpu_wdata = data;
		cpu_wr    = 1'b1; // one-cycle strobe
		@(negedge clk_cpu);
		cpu_wr = 1'b0;
	endtask

	task automatic bus_read(input logic [15:0] addr, input logic [7:0] expected);
		cpu_addr = addr;
		cpu_rd   = 1'b1;
		exp_data = expected;
		chk_en   = 1'b1;
		checks++;
		@(negedge clk_cpu);
		cpu_rd = 1'b0;
		chk_en = 1'b0;
	endtask

	// ack cycle returns the vector on the data bus
	task automatic ack_read(input logic [7:0] vector);
		irq_ack  = 1'b1;
		exp_data = vector;
		chk_en   = 1'b1;
		checks++;
		@(negedge clk_cpu);
		irq_ack = 1'b0;
		chk_en  = 1'b0;
	endtask

	task automatic expect_vector(input logic irq_level, input logic [7:0] vector);
		exp_irq = irq_level;
		exp_vec = vector;
		vec_en  = 1'b1;
		checks++;
		@(negedge clk_cpu);
		vec_en = 1'b0;
	endtask

	always @(posedge clk_cpu) begin
		exp_q  <= exp_data;
		addr_q <= cpu_addr;
	end

	// ------------------------------------------------
	// checkers
	// ------------------------------------------------
	read_data: assert property (@(posedge clk_cpu) disable iff (reset)
		chk_en |=> cpu_rdata == exp_q)
	else begin
		errors++;
		$display("FAILED %0t: read of %h returned %h, expected %h",
			$time, $sampled(addr_q), $sampled(cpu_rdata), $sampled(exp_q));
	end

	vector_out: assert property (@(posedge clk_cpu) disable iff (reset)
		vec_en |-> irq == exp_irq && irq_vector == exp_vec)
	else begin
		errors++;
		$display("FAILED %0t: irq %b vector %h, expected irq %b vector %h", $time,
			$sampled(irq), $sampled(irq_vector), $sampled(exp_irq), $sampled(exp_vec));
	end

	// strobes pass straight through for cart space only
	cart_strobes: assert property (@(posedge clk_cpu) disable iff (reset)
		cart_rd == (cpu_rd && in_cart(cpu_addr)) && cart_wr == (cpu_wr && in_cart(cpu_addr)))
	else begin
		errors++;
		$display("FAILED %0t: cart_rd %b cart_wr %b wrong for address %h",
			$time, $sampled(cart_rd), $sampled(cart_wr), $sampled(cpu_addr));
	end

	// cart bus carries the CPU address and the written byte
	cart_bus: assert property (@(posedge clk_cpu) disable iff (reset)
		cart_addr == cpu_addr && (!cart_wr || cart_wdata == cpu_wdata))
	else begin
		errors++;
		$display("FAILED %0t: cart address %h data %h, expected address %h data %h", $time,
			$sampled(cart_addr), $sampled(cart_wdata), $sampled(cpu_addr), $sampled(cpu_wdata));
	end

	reset_idle: assert property (@(posedge clk_cpu) reset |=> !irq && !cart_rd && !cart_wr)
	else begin
		errors++;
		$display("FAILED %0t: irq or cart strobe active after reset", $time);
	end

endmodule

`default_nettype wire

//--- testbench/tb_gb_bus.sv
// ------------------------------------------------
// serial divider shortened to 4 bits
// ------------------------------------------------
`default_nettype none

module tb_gb_bus
	import gb_memmap_pkg::*, gb_irq_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int N_WRAM          = 32;
	localparam int SERIAL_WAIT     = 300;  // 8 x 16 cycles plus margin
	localparam int WATCHDOG_CYCLES = 2000; // roughly 530 used, mostly the ram test

	logic              clk_cpu = 1'b0;
	logic              reset;
	logic              cgb_mode;
	logic              fast_boot;
	logic [7:0]        joystick;
	logic              vblank;
	logic              lcd_irq;
	logic              timer_irq;
	logic [ADDR_W-1:0] cpu_addr;
	logic [DATA_W-1:0] cpu_wdata;
	logic              cpu_rd;
	logic              cpu_wr;
	logic              irq_ack;
	logic [DATA_W-1:0] cart_rdata;
	logic [DATA_W-1:0] bios_rdata;
	logic [DATA_W-1:0] cpu_rdata;
	logic              irq;
	logic [DATA_W-1:0] irq_vector;
	logic [ADDR_W-1:0] cart_addr;
	logic [DATA_W-1:0] cart_wdata;
	logic              cart_rd;
	logic              cart_wr;
	logic [11:0]       bios_addr;

	logic [15:0] wram_addr [N_WRAM];
	logic [7:0]  wram_img [N_WRAM];
	logic [7:0]  hram_img [127];
	logic [7:0]  x;
	int unsigned seed_draw;
	int          n_tests = 0;
	int          n_failed = 0;
	int          err_mark;
	int          tb_errors = 0; // timeouts seen by the tests

	always #4 clk_cpu = ~clk_cpu; // 8 ns

	// external memory models with patterns over the whole address
	function automatic logic [7:0] cart_byte(input logic [15:0] a);
		return a[15:8] ^ a[7:0] ^ 8'h3C;
	endfunction

	function automatic logic [7:0] bios_byte(input logic [11:0] a);
		return {a[11:8], 4'h0} + a[7:0] + 8'h91;
	endfunction

	assign cart_rdata = cart_byte(cart_addr);
	assign bios_rdata = bios_byte(bios_addr);

	// expected P1 byte with low active rows
	// deselected row reads all 1s
	function automatic logic [7:0] p1_expect(input logic [1:0] sel, input logic [7:0] keys);
		logic [3:0] dir;
		logic [3:0] btn;
		dir = sel[0] ? 4'hF : ~keys[3:0];
		btn = sel[1] ? 4'hF : ~keys[7:4];
		return {2'b11, sel, dir & btn};
	endfunction

	gb_bus_top #(.SERIAL_DIV_W(4)) UUT (
		.clk_cpu, .reset, .cgb_mode, .fast_boot, .joystick,
		.cpu_addr, .cpu_wdata, .cpu_rd, .cpu_wr, .irq_ack,
		.vblank, .lcd_irq, .timer_irq, .cart_rdata, .bios_rdata,
		.cpu_rdata, .irq, .irq_vector,
		.cart_addr, .cart_wdata, .cart_rd, .cart_wr, .bios_addr
	);

	tb_gb_bus_checks u_chk (
		.clk_cpu, .reset, .cpu_rdata, .irq, .irq_vector, .cart_rd, .cart_wr,
		.cart_addr, .cart_wdata,
		.cpu_addr, .cpu_wdata, .cpu_rd, .cpu_wr, .irq_ack
	);

	task automatic open_test();
		err_mark = u_chk.errors + tb_errors;
	endtask

	task automatic close_test(input string name);
		repeat (2) @(negedge clk_cpu); // last read check lands here
		n_tests++;
		if (u_chk.errors + tb_errors != err_mark) begin
			n_failed++;
			$display("test %0d %s: failed", n_tests, name);
		end else begin
			$display("test %0d %s: passed", n_tests, name);
		end
	endtask

	task automatic wait_irq(input int limit);
		int n;
		n = 0;
		while (!irq && n < limit) begin
			@(negedge clk_cpu);
			n++;
		end
		if (!irq) begin
			tb_errors++;
			$display("irq never went high within %0d cycles, at %0t", limit, $time);
		end
	endtask

	// ------------------------------------------------
	// stimulus
	// ------------------------------------------------
	initial begin
		seed_draw = $urandom(42);
		reset     = 1'b1;
		cgb_mode  = 1'b0;
		fast_boot = 1'b1;
		joystick  = 8'h00;
		vblank    = 1'b0;
		lcd_irq   = 1'b0;
		timer_irq = 1'b0;
		repeat (3) @(posedge clk_cpu);
		@(negedge clk_cpu);
		reset = 1'b0;

		open_test();
		for (int i = 0; i < N_WRAM; i++) begin
			wram_addr[i] = 16'hC000 + 16'(i * 128) + 16'($urandom % 128); // distinct
			wram_img[i]  = 8'($urandom);
			u_chk.bus_write(wram_addr[i], wram_img[i]);
		end
		for (int i = 0; i < 127; i++) begin
			hram_img[i] = 8'($urandom);
			u_chk.bus_write(16'hFF80 + 16'(i), hram_img[i]);
		end
		for (int i = 0; i < N_WRAM; i++)
			u_chk.bus_read(wram_addr[i], wram_img[i]);
		for (int i = 0; i < 127; i++)
			u_chk.bus_read(16'hFF80 + 16'(i), hram_img[i]);
		u_chk.bus_read(REG_SVBK, 8'hFF); // no SVBK in mono
		u_chk.bus_write(REG_SVBK, 8'h03);
		cgb_mode = 1'b1;
		u_chk.bus_read(REG_SVBK, 8'hF9); // still bank 1
		x = 8'($urandom);
		u_chk.bus_write(REG_SVBK, 8'h02);
		u_chk.bus_write(16'hD000, x);
		u_chk.bus_write(REG_SVBK, 8'h03);
		u_chk.bus_write(16'hD000, ~x);
		u_chk.bus_read(16'hD000, ~x);
		u_chk.bus_write(REG_SVBK, 8'h02);
		u_chk.bus_read(16'hD000, x);
		u_chk.bus_write(REG_SVBK, 8'h00); // stored as 1
		u_chk.bus_read(REG_SVBK, 8'hF9);
		cgb_mode = 1'b0;
		close_test("ram and banking");

		open_test();
		u_chk.bus_write(REG_IE, 8'h1F);
		u_chk.bus_read(REG_IE, 8'h1F);
		u_chk.expect_vector(1'b0, 8'h55);
		timer_irq = 1'b1;
		lcd_irq   = 1'b1;
		@(negedge clk_cpu);
		timer_irq = 1'b0;
		lcd_irq   = 1'b0;
		u_chk.expect_vector(1'b1, 8'h48); // lcd beats timer
		u_chk.ack_read(8'h48);
		u_chk.expect_vector(1'b1, 8'h50);
		u_chk.bus_read(REG_IF, 8'hE4);
		u_chk.bus_write(REG_IF, 8'h00);
		u_chk.expect_vector(1'b0, 8'h55);
		close_test("interrupt priority");

		open_test();
		vblank = 1'b1;
		@(negedge clk_cpu);
		u_chk.bus_read(REG_IF, 8'hE1);
		u_chk.expect_vector(1'b1, 8'h40);
		u_chk.bus_write(REG_IF, 8'h00);
		repeat (4) @(negedge clk_cpu); // level held without a new edge
		u_chk.bus_read(REG_IF, 8'hE0);
		vblank = 1'b0;
		close_test("vblank edge");

		open_test();
		u_chk.bus_write(REG_P1, 8'h20); // direction row
		u_chk.bus_read(REG_P1, p1_expect(2'b10, 8'h00));
		joystick = 8'h09; // right and down
		@(negedge clk_cpu);
		u_chk.bus_read(REG_P1, p1_expect(2'b10, 8'h09));
		u_chk.bus_read(REG_IF, 8'hE0 | (8'h01 << IRQ_JOYPAD));
		u_chk.bus_write(REG_IF, 8'h00);
		u_chk.bus_write(REG_P1, 8'h10); // button row
		joystick = 8'h29; // b added
		@(negedge clk_cpu);
		u_chk.bus_read(REG_P1, p1_expect(2'b01, 8'h29));
		u_chk.bus_read(REG_IF, 8'hE0 | (8'h01 << IRQ_JOYPAD));
		joystick = 8'h00;
		u_chk.bus_write(REG_IF, 8'h00);
		close_test("joypad");

		open_test();
		u_chk.bus_write(REG_SC, 8'h81);
		u_chk.bus_read(REG_SC, 8'hFF); // busy
		wait_irq(SERIAL_WAIT);
		u_chk.expect_vector(1'b1, 8'h58);
		u_chk.bus_read(REG_IF, 8'hE0 | (8'h01 << IRQ_SERIAL));
		u_chk.bus_read(REG_SC, 8'h7F);
		u_chk.bus_write(REG_IF, 8'h00);
		close_test("serial");

		open_test();
		u_chk.bus_read(16'h0000, bios_byte(12'h000));
		u_chk.bus_read(16'h00A7, bios_byte(12'h0A7));
		u_chk.bus_read(16'h0150, cart_byte(16'h0150)); // header not overlaid
		u_chk.bus_read(REG_BOOT, 8'h42);
		u_chk.bus_write(REG_BOOT, 8'h01);
		u_chk.bus_read(16'h0000, cart_byte(16'h0000));
		u_chk.bus_read(REG_BOOT, 8'hFF);
		x = 8'($urandom);
		u_chk.bus_write(16'hA000, x); // cart_wr strobe
		u_chk.bus_read(16'hFF03, 8'hFF);
		u_chk.bus_read(REG_SB, 8'hFF);
		close_test("boot overlay and cartridge");

		$display("%0d tests run, %0d failed, %0d checks issued, %0d errors",
			n_tests, n_failed, u_chk.checks, u_chk.errors + tb_errors);
		if (n_failed == 0 && u_chk.errors + tb_errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_cpu);
		$display("watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
		$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
logic/gb_memmap_pkg.sv
logic/gb_irq_pkg.sv
logic/spram.sv
logic/cpu_bus_mux.sv
logic/irq_controller.sv
logic/joypad.sv
logic/serial_ctrl.sv
logic/work_ram.sv
logic/cart_rom_ctrl.sv
logic/gb_bus_top.sv
testbench/tb_gb_bus_checks.sv
testbench/tb_gb_bus.sv
